/* hw/l2_pkg.sv */
// Shared geometry and types for the 8-way set-associative L2 cache.
// Every cache module and interface imports this package with a wildcard
// import in its header.

`default_nettype none

package l2_pkg;

  // ====================
  // Geometry
  // ====================
  localparam int ADDR_W      = 32;
  localparam int LINE_W      = 128;
  localparam int NUM_WAY     = 8;
  localparam int CACHE_BYTES = 4096;
  localparam int NUM_SET     = CACHE_BYTES / (LINE_W / 8) / NUM_WAY;
  localparam int IDX_W       = $clog2(NUM_SET);
  localparam int OFFSET_W    = $clog2(LINE_W / 8);
  localparam int TAG_W       = ADDR_W - IDX_W - OFFSET_W;
  localparam int ID_W        = 4;

  // Depth of the pseudo-LRU tree
  localparam int PLRU_LVL    = $clog2(NUM_WAY);

  // ====================
  // Types
  // ====================
  typedef logic [LINE_W-1:0] line_t;

  typedef struct packed {
    logic             valid;
    logic [TAG_W-1:0] tag;
  } tag_entry_t;

  // One-hot way select or per-way mask
  typedef logic [NUM_WAY-1:0] way_vec_t;

  // Heap-ordered tree bits of one set with the root at bit 0
  typedef logic [NUM_WAY-2:0] plru_t;

endpackage

`default_nettype wire

/* hw/l2_array_if.sv */
// Array port between the lookup stage and the store.
// The lookup stage drives the read index, the single write port and the
// PLRU touch. The store answers with the set read one cycle earlier.

`timescale 1ns/1ps
`default_nettype none

interface l2_array_if
  import l2_pkg::*;
();

  // Read side
  logic [IDX_W-1:0]               rd_idx;
  tag_entry_t [NUM_WAY-1:0]       rtag;
  line_t [NUM_WAY-1:0]            rdata;
  way_vec_t                       dirty_vec;
  way_vec_t                       victim_way;

  // Write port and PLRU touch for the set at wr_idx
  logic                           wr_en;
  way_vec_t                       wr_way;
  logic [IDX_W-1:0]               wr_idx;
  logic [TAG_W-1:0]               wr_tag;
  line_t                          wr_data;
  logic                           wr_dirty;
  logic                           touch_en;
  way_vec_t                       touch_way;

  // Sweep handshake
  logic                           busy;
  logic                           sweeping;

  modport lookup (
    output rd_idx, wr_en, wr_way, wr_idx, wr_tag, wr_data, wr_dirty,
    output touch_en, touch_way, busy,
    input  rtag, rdata, dirty_vec, victim_way, sweeping
  );

  modport store (
    input  rd_idx, wr_en, wr_way, wr_idx, wr_tag, wr_data, wr_dirty,
    input  touch_en, touch_way, busy,
    output rtag, rdata, dirty_vec, victim_way, sweeping
  );

endinterface

`default_nettype wire

/* hw/l2_miss_if.sv */
// Miss hand-off between the lookup stage and the miss stage.
// The lookup stage strobes miss_valid once per miss with the victim
// details; the miss stage strobes fill_valid with the refilled line.

`timescale 1ns/1ps
`default_nettype none

interface l2_miss_if
  import l2_pkg::*;
();

  logic              miss_valid;
  logic [ADDR_W-1:0] miss_addr;
  logic              wb_needed;
  logic [ADDR_W-1:0] wb_addr;
  line_t             wb_data;

  logic              fill_valid;
  line_t             fill_data;

  modport lookup (
    output miss_valid, miss_addr, wb_needed, wb_addr, wb_data,
    input  fill_valid, fill_data
  );

  modport miss (
    input  miss_valid, miss_addr, wb_needed, wb_addr, wb_data,
    output fill_valid, fill_data
  );

endinterface

`default_nettype wire

/* hw/l2_set_ram.sv */
// Single-port synchronous memory with one entry per cache set.
// Read-first: the output shows the old entry of the addressed set one
// cycle later. The entry type selects tag or data storage.

`timescale 1ns/1ps
`default_nettype none

module l2_set_ram
  import l2_pkg::*;
#(
  parameter type entry_t = logic
) (
  input  logic             clk_i,
  input  logic [IDX_W-1:0] idx_i,
  input  logic             wr_en_i,
  input  entry_t           wr_entry_i,
  output entry_t           rd_entry_o
);

  entry_t mem_q [NUM_SET];

  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      mem_q[idx_i] <= wr_entry_i;
    end
    rd_entry_o <= mem_q[idx_i];
  end

endmodule

`default_nettype wire

/* hw/l2_store.sv */
// Storage of the L2 cache: tag and data ways, dirty bits, PLRU trees.
// Also runs the sweep that invalidates every set after reset and after
// a flush request, once the lookup stage has gone idle.

`timescale 1ns/1ps
`default_nettype none

module l2_store
  import l2_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      flush_i,
  l2_array_if.store arr
);

  logic             sweep_q;
  logic             flush_pend_q;
  logic [IDX_W-1:0] sweep_idx_q;
  logic [IDX_W-1:0] ram_idx;
  logic [IDX_W-1:0] idx_q;
  way_vec_t         tag_we;
  way_vec_t         data_we;
  tag_entry_t       tag_wr;
  way_vec_t         dirty_q [NUM_SET];
  plru_t            plru_q [NUM_SET];

  // Walk from the root following the bits towards the LRU leaf
  function automatic way_vec_t plru_victim(plru_t bits);
    int       node;
    way_vec_t way;
    node = 0;
    for (int lvl = 0; lvl < PLRU_LVL; lvl++) begin
      node = 2 * node + 1 + int'(bits[node]);
    end
    way = '0;
    way[node - (NUM_WAY - 1)] = 1'b1;
    return way;
  endfunction

  // Walk up from the touched leaf and point each parent the other way
  function automatic plru_t plru_touch(plru_t bits, way_vec_t way);
    plru_t res;
    int    node;
    res  = bits;
    node = 0;
    for (int w = 0; w < NUM_WAY; w++) begin
      if (way[w]) node = w + NUM_WAY - 1;
    end
    for (int lvl = 0; lvl < PLRU_LVL; lvl++) begin
      // Odd heap index is a left child, so the LRU side is the right one
      res[(node - 1) / 2] = node[0];
      node = (node - 1) / 2;
    end
    return res;
  endfunction

  // ====================
  // Way arrays
  // ====================
  assign ram_idx = sweep_q ? sweep_idx_q : (arr.wr_en ? arr.wr_idx : arr.rd_idx);
  assign tag_wr  = sweep_q ? '0 : tag_entry_t'{valid: 1'b1, tag: arr.wr_tag};
  assign tag_we  = sweep_q ? '1 : (arr.wr_en ? arr.wr_way : '0);
  assign data_we = (arr.wr_en && !sweep_q) ? arr.wr_way : '0;

  for (genvar w = 0; w < NUM_WAY; w++) begin : g_way
    l2_set_ram #(.entry_t(tag_entry_t)) tag_ram_i (
      .clk_i      (clk_i),
      .idx_i      (ram_idx),
      .wr_en_i    (tag_we[w]),
      .wr_entry_i (tag_wr),
      .rd_entry_o (arr.rtag[w])
    );

    l2_set_ram #(.entry_t(line_t)) data_ram_i (
      .clk_i      (clk_i),
      .idx_i      (ram_idx),
      .wr_en_i    (data_we[w]),
      .wr_entry_i (arr.wr_data),
      .rd_entry_o (arr.rdata[w])
    );
  end

  // ====================
  // Dirty and PLRU state
  // ====================
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      for (int i = 0; i < NUM_SET; i++) begin
        dirty_q[i] <= '0;
        plru_q[i]  <= '0;
      end
    end else if (sweep_q) begin
      dirty_q[sweep_idx_q] <= '0;
      plru_q[sweep_idx_q]  <= '0;
    end else begin
      for (int w = 0; w < NUM_WAY; w++) begin
        if (arr.wr_en && arr.wr_way[w]) dirty_q[arr.wr_idx][w] <= arr.wr_dirty;
      end
      if (arr.touch_en) plru_q[arr.wr_idx] <= plru_touch(plru_q[arr.wr_idx], arr.touch_way);
    end
  end

  // Registered index lines the side state up with the RAM outputs
  always_ff @(posedge clk_i) begin
    idx_q <= ram_idx;
  end

  assign arr.dirty_vec  = dirty_q[idx_q];
  assign arr.victim_way = plru_victim(plru_q[idx_q]);

  // ====================
  // Sweep
  // ====================
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      sweep_q      <= 1'b1;
      flush_pend_q <= 1'b0;
      sweep_idx_q  <= '0;
    end else begin
      if (flush_i) flush_pend_q <= 1'b1;
      if (sweep_q) begin
        sweep_idx_q <= sweep_idx_q + 1'b1;
        if (sweep_idx_q == IDX_W'(NUM_SET - 1)) sweep_q <= 1'b0;
      end else if (flush_pend_q && !arr.busy) begin
        sweep_q      <= 1'b1;
        flush_pend_q <= 1'b0;
      end
    end
  end

  // Pending flush already stops new requests
  assign arr.sweeping = sweep_q || flush_pend_q;

endmodule

`default_nettype wire

/* hw/l2_lookup_stage.sv */
// Lookup stage of the L2 cache.
// Registers an accepted request, compares its tag against all ways of the
// set and answers a hit in the next cycle. A miss is handed to the miss
// stage; the refilled line is written one cycle after fill_valid.

`timescale 1ns/1ps
`default_nettype none

module l2_lookup_stage
  import l2_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              req_valid_i,
  input  logic              req_write_i,
  input  logic [ADDR_W-1:0] req_addr_i,
  input  line_t             req_data_i,
  input  logic [ID_W-1:0]   req_id_i,
  output logic              req_ready_o,
  output logic              res_valid_o,
  output line_t             res_data_o,
  output logic [ID_W-1:0]   res_id_o,
  l2_array_if.lookup        arr,
  l2_miss_if.lookup         miss
);

  typedef enum logic [1:0] {S_IDLE, S_LOOKUP, S_MISS, S_FILL} state_e;

  state_e            state_q;
  state_e            state_d;
  logic              req_write_q;
  logic [ADDR_W-1:0] req_addr_q;
  line_t             req_data_q;
  logic [ID_W-1:0]   req_id_q;
  way_vec_t          victim_q;
  logic [TAG_W-1:0]  req_tag;
  logic [IDX_W-1:0]  req_idx;
  way_vec_t          hit_vec;
  line_t             hit_data;
  tag_entry_t        victim_tag;
  line_t             victim_data;
  logic              lookup_hit;
  logic              accept;

  assign req_tag = req_addr_q[ADDR_W-1 -: TAG_W];
  assign req_idx = req_addr_q[OFFSET_W +: IDX_W];

  // ====================
  // Tag compare
  // ====================
  always_comb begin
    hit_vec     = '0;
    hit_data    = '0;
    victim_tag  = '0;
    victim_data = '0;
    for (int w = 0; w < NUM_WAY; w++) begin
      hit_vec[w] = arr.rtag[w].valid && (arr.rtag[w].tag == req_tag);
      if (hit_vec[w]) hit_data = arr.rdata[w];
      if (arr.victim_way[w]) begin
        victim_tag  = arr.rtag[w];
        victim_data = arr.rdata[w];
      end
    end
  end

  assign lookup_hit = (state_q == S_LOOKUP) && (|hit_vec);

  // Only a read hit frees the set port for the next request
  assign req_ready_o = !arr.sweeping &&
                       ((state_q == S_IDLE) || (lookup_hit && !req_write_q));
  assign accept      = req_valid_i && req_ready_o;

  assign res_valid_o = lookup_hit || (state_q == S_FILL);
  assign res_data_o  = (lookup_hit && !req_write_q) ? hit_data : req_data_q;
  assign res_id_o    = req_id_q;

  // ====================
  // Array and miss ports
  // ====================
  assign arr.rd_idx    = req_addr_i[OFFSET_W +: IDX_W];
  assign arr.wr_idx    = req_idx;
  assign arr.wr_tag    = req_tag;
  assign arr.wr_data   = req_data_q;
  assign arr.wr_en     = (lookup_hit && req_write_q) || (state_q == S_FILL);
  assign arr.wr_way    = (state_q == S_FILL) ? victim_q : hit_vec;
  assign arr.wr_dirty  = req_write_q;
  assign arr.touch_en  = res_valid_o;
  assign arr.touch_way = arr.wr_way;
  assign arr.busy      = state_q != S_IDLE;

  assign miss.miss_valid = (state_q == S_LOOKUP) && !(|hit_vec);
  assign miss.miss_addr  = {req_addr_q[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
  assign miss.wb_needed  = victim_tag.valid && (|(arr.dirty_vec & arr.victim_way));
  assign miss.wb_addr    = {victim_tag.tag, req_idx, {OFFSET_W{1'b0}}};
  assign miss.wb_data    = victim_data;

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE:   if (accept) state_d = S_LOOKUP;
      S_LOOKUP: state_d = !(|hit_vec) ? S_MISS : (accept ? S_LOOKUP : S_IDLE);
      S_MISS:   if (miss.fill_valid) state_d = S_FILL;
      default:  state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= S_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // A read miss keeps the refilled line in the request data register
  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_write_q <= req_write_i;
      req_addr_q  <= req_addr_i;
      req_data_q  <= req_data_i;
      req_id_q    <= req_id_i;
    end else if (state_q == S_MISS && miss.fill_valid && !req_write_q) begin
      req_data_q  <= miss.fill_data;
    end
    if (miss.miss_valid) victim_q <= arr.victim_way;
  end

endmodule

`default_nettype wire

/* hw/l2_miss_stage.sv */
// Miss stage of the L2 cache.
// Takes one miss at a time from the lookup stage, writes back the dirty
// victim first when needed, then reads the line-aligned address from
// memory and returns it on fill_valid.

`timescale 1ns/1ps
`default_nettype none

module l2_miss_stage
  import l2_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  l2_miss_if.miss           miss,
  output logic              mem_req_valid_o,
  output logic              mem_req_write_o,
  output logic [ADDR_W-1:0] mem_req_addr_o,
  output line_t             mem_req_data_o,
  input  logic              mem_req_ready_i,
  input  logic              mem_res_valid_i,
  input  line_t             mem_res_data_i
);

  typedef enum logic [2:0] {
    M_IDLE,
    M_WB_REQ,
    M_WB_WAIT,
    M_RF_REQ,
    M_RF_WAIT
  } state_e;

  state_e            state_q;
  state_e            state_d;
  logic [ADDR_W-1:0] line_addr_q;
  logic [ADDR_W-1:0] wb_addr_q;
  line_t             wb_data_q;
  logic              take_miss;

  assign take_miss = (state_q == M_IDLE) && miss.miss_valid;

  always_comb begin
    state_d = state_q;
    case (state_q)
      M_IDLE:    if (miss.miss_valid) state_d = miss.wb_needed ? M_WB_REQ : M_RF_REQ;
      M_WB_REQ:  if (mem_req_ready_i) state_d = M_WB_WAIT;
      // Writeback response is only an acknowledge
      M_WB_WAIT: if (mem_res_valid_i) state_d = M_RF_REQ;
      M_RF_REQ:  if (mem_req_ready_i) state_d = M_RF_WAIT;
      M_RF_WAIT: if (mem_res_valid_i) state_d = M_IDLE;
      default:   state_d = M_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= M_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Victim line and refill address are captured once per miss
  always_ff @(posedge clk_i) begin
    if (take_miss) begin
      line_addr_q <= miss.miss_addr;
      wb_addr_q   <= miss.wb_addr;
      wb_data_q   <= miss.wb_data;
    end
  end

  // ====================
  // Memory request
  // ====================
  assign mem_req_valid_o = (state_q == M_WB_REQ) || (state_q == M_RF_REQ);
  assign mem_req_write_o = state_q == M_WB_REQ;
  assign mem_req_addr_o  = (state_q == M_WB_REQ) ? wb_addr_q : line_addr_q;
  assign mem_req_data_o  = wb_data_q;

  assign miss.fill_valid = (state_q == M_RF_WAIT) && mem_res_valid_i;
  assign miss.fill_data  = mem_res_data_i;

endmodule

`default_nettype wire

/* hw/l2_cache.sv */
// Top level of the blocking write-back L2 cache.
// Request side uses valid/ready, responses are a one-cycle valid pulse.
// Memory requests are held until accepted and answered by one pulse each.

`timescale 1ns/1ps
`default_nettype none

module l2_cache
  import l2_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              flush_i,
  input  logic              req_valid_i,
  input  logic              req_write_i,
  input  logic [ADDR_W-1:0] req_addr_i,
  input  line_t             req_data_i,
  input  logic [ID_W-1:0]   req_id_i,
  output logic              req_ready_o,
  output logic              res_valid_o,
  output line_t             res_data_o,
  output logic [ID_W-1:0]   res_id_o,
  output logic              mem_req_valid_o,
  output logic              mem_req_write_o,
  output logic [ADDR_W-1:0] mem_req_addr_o,
  output line_t             mem_req_data_o,
  input  logic              mem_req_ready_i,
  input  logic              mem_res_valid_i,
  input  line_t             mem_res_data_i
);

  l2_array_if arr_if ();
  l2_miss_if  miss_if ();

  l2_store store_i (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .flush_i (flush_i),
    .arr     (arr_if.store)
  );

  l2_lookup_stage lookup_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (req_valid_i),
    .req_write_i (req_write_i),
    .req_addr_i  (req_addr_i),
    .req_data_i  (req_data_i),
    .req_id_i    (req_id_i),
    .req_ready_o (req_ready_o),
    .res_valid_o (res_valid_o),
    .res_data_o  (res_data_o),
    .res_id_o    (res_id_o),
    .arr         (arr_if.lookup),
    .miss        (miss_if.lookup)
  );

  l2_miss_stage miss_i (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .miss            (miss_if.miss),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_write_o (mem_req_write_o),
    .mem_req_addr_o  (mem_req_addr_o),
    .mem_req_data_o  (mem_req_data_o),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_res_valid_i (mem_res_valid_i),
    .mem_res_data_i  (mem_res_data_i)
  );

endmodule

`default_nettype wire

/* verif/l2_cache_properties.sv */
// Concurrent assertions for the L2 cache top level.
// Bound into every l2_cache instance.

`timescale 1ns/1ps
`default_nettype none

module l2_cache_properties
  import l2_pkg::*;
(
  input wire logic              clk_i,
  input wire logic              rst_ni,
  input wire logic              req_valid_i,
  input wire logic              req_ready_o,
  input wire logic              res_valid_o,
  input wire logic              mem_req_valid_o,
  input wire logic              mem_req_write_o,
  input wire logic [ADDR_W-1:0] mem_req_addr_o,
  input wire line_t             mem_req_data_o,
  input wire logic              mem_req_ready_i
);

  logic [IDX_W:0] sweep_left_q;

  // Cycles of the reset sweep still to come
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      sweep_left_q <= (IDX_W + 1)'(NUM_SET);
    end else if (sweep_left_q != '0) begin
      sweep_left_q <= sweep_left_q - 1'b1;
    end
  end

  // Memory request held stable until accepted
  mem_req_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o && $stable(mem_req_write_o)
      && $stable(mem_req_addr_o) && $stable(mem_req_data_o))
    else $error("memory request changed before it was accepted");

  // Sweep after reset keeps the request side closed and quiet
  sweep_quiet_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    sweep_left_q != '0 |-> !res_valid_o && !req_ready_o && !mem_req_valid_o)
    else $error("response, ready or memory request seen during the reset sweep");

  // A response lasts one cycle unless a new request was taken
  res_pulse_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    res_valid_o && !(req_valid_i && req_ready_o) |=> !res_valid_o)
    else $error("response valid held longer than one cycle");

endmodule

bind l2_cache l2_cache_properties props_i (
  .clk_i           (clk_i),
  .rst_ni          (rst_ni),
  .req_valid_i     (req_valid_i),
  .req_ready_o     (req_ready_o),
  .res_valid_o     (res_valid_o),
  .mem_req_valid_o (mem_req_valid_o),
  .mem_req_write_o (mem_req_write_o),
  .mem_req_addr_o  (mem_req_addr_o),
  .mem_req_data_o  (mem_req_data_o),
  .mem_req_ready_i (mem_req_ready_i)
);

`default_nettype wire

/* verif/tb_l2_cache.sv */
// Testbench for the L2 cache top level.
// Reads commands from the input file, models memory with a random latency
// and checks every response and writeback against a line model.

`timescale 1ns/1ps
`default_nettype none

module tb_l2_cache
  import l2_pkg::*;
;

  localparam int TIMEOUT = 300;

  logic              clk_i = 1'b0;
  logic              rst_ni;
  logic              flush_i;
  logic              req_valid_i;
  logic              req_write_i;
  logic [ADDR_W-1:0] req_addr_i;
  line_t             req_data_i;
  logic [ID_W-1:0]   req_id_i;
  logic              req_ready_o;
  logic              res_valid_o;
  line_t             res_data_o;
  logic [ID_W-1:0]   res_id_o;
  logic              mem_req_valid_o;
  logic              mem_req_write_o;
  logic [ADDR_W-1:0] mem_req_addr_o;
  line_t             mem_req_data_o;
  logic              mem_req_ready_i;
  logic              mem_res_valid_i;
  line_t             mem_res_data_i;

  line_t mem_tab [logic [ADDR_W-1:0]];
  line_t model [logic [ADDR_W-1:0]];
  // Request order of each line and the lines the cache holds dirty
  int    last_use [logic [ADDR_W-1:0]];
  logic  dirty_line [logic [ADDR_W-1:0]];
  int mismatches = 0;
  int failures = 0;
  int mem_reqs = 0;
  int wb_count = 0;
  int use_cnt = 0;
  integer seed = 32'hdf3d;

  l2_cache dut_i (.*);

  always #2 clk_i = ~clk_i;

  function automatic line_t mem_line(logic [ADDR_W-1:0] a);
    return mem_tab.exists(a) ? mem_tab[a] : {4{a}};
  endfunction

  // ====================
  // Memory model
  // ====================
  initial begin : memory_model
    logic wr;
    logic [ADDR_W-1:0] a;
    line_t d;
    int lat;
    int stall;
    forever begin
      @(posedge clk_i);
      #1;
      if (mem_req_valid_o) begin
        mem_reqs++;
        // Hold off acceptance for a few cycles
        stall = $unsigned($random(seed)) % 3;
        for (int i = 0; i < stall; i++) begin
          @(posedge clk_i);
          #1;
        end
        wr = mem_req_write_o;
        a = mem_req_addr_o;
        d = mem_req_data_o;
        mem_req_ready_i = 1'b1;
        @(posedge clk_i);
        #1;
        mem_req_ready_i = 1'b0;
        if (wr) begin
          wb_count++;
          if (!model.exists(a)) begin
            failures++;
            $display("writeback of line %h that was never written", a);
          end else begin
            if (d != model[a]) begin
              mismatches++;
              $display("mismatch at %0t: writeback %h data %h expected %h",
                       $time, a, d, model[a]);
            end
            foreach (dirty_line[b]) begin
              if (b != a && b[OFFSET_W +: IDX_W] == a[OFFSET_W +: IDX_W] &&
                  last_use[b] < last_use[a]) begin
                mismatches++;
                $display("mismatch at %0t: writeback of %h while %h was used less recently",
                         $time, a, b);
              end
            end
          end
          dirty_line.delete(a);
          mem_tab[a] = d;
        end
        lat = 1 + ($unsigned($random(seed)) % 6);
        for (int i = 1; i < lat; i++) begin
          @(posedge clk_i);
          #1;
        end
        mem_res_data_i = wr ? '0 : mem_line(a);
        mem_res_valid_i = 1'b1;
        @(posedge clk_i);
        #1;
        mem_res_valid_i = 1'b0;
      end
    end
  end

  // Drive one request, wait for acceptance and the response, then check it
  task automatic do_request(input logic wr, input logic [ADDR_W-1:0] a, input line_t d,
                            input logic [ID_W-1:0] id, input logic expect_hit);
    logic acc;
    int wait_cnt;
    int lat;
    int reqs_before;
    line_t exp;
    req_valid_i = 1'b1;
    req_write_i = wr;
    req_addr_i = a;
    req_data_i = d;
    req_id_i = id;
    acc = 1'b0;
    wait_cnt = 0;
    while (!acc && wait_cnt < TIMEOUT) begin
      #2;
      acc = req_ready_o;
      @(posedge clk_i);
      #1;
      wait_cnt++;
    end
    req_valid_i = 1'b0;
    if (!acc) begin
      failures++;
      $display("request for %h was never accepted", a);
      return;
    end
    last_use[a] = use_cnt;
    use_cnt++;
    reqs_before = mem_reqs;
    lat = 1;
    #2;
    while (!res_valid_o && lat < TIMEOUT) begin
      @(posedge clk_i);
      #3;
      lat++;
    end
    if (!res_valid_o) begin
      failures++;
      $display("no response for request to %h", a);
      return;
    end
    exp = wr ? d : (model.exists(a) ? model[a] : mem_line(a));
    if (res_data_o != exp || res_id_o != id) begin
      mismatches++;
      $display("mismatch at %0t: %h got data %h id %h, expected %h id %h",
               $time, a, res_data_o, res_id_o, exp, id);
    end
    if (expect_hit && (lat != 1 || mem_reqs != reqs_before)) begin
      mismatches++;
      $display("mismatch at %0t: repeated read of %h took %0d cycles with memory traffic",
               $time, a, lat);
    end
    if (wr) begin
      model[a] = d;
      dirty_line[a] = 1'b1;
    end
    @(posedge clk_i);
    #1;
  endtask

  initial begin : stimulus
    int fd;
    int n;
    string line;
    string cmd;
    logic [ADDR_W-1:0] addr;
    logic [31:0] data;
    logic [ID_W-1:0] id;
    logic [ADDR_W-1:0] prev_line;
    logic have_prev;
    rst_ni = 1'b0;
    flush_i = 1'b0;
    req_valid_i = 1'b0;
    req_write_i = 1'b0;
    req_addr_i = '0;
    req_data_i = '0;
    req_id_i = '0;
    mem_req_ready_i = 1'b0;
    mem_res_valid_i = 1'b0;
    mem_res_data_i = '0;
    have_prev = 1'b0;
    prev_line = '0;
    repeat (8) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    fd = $fopen("verif/l2_cache_input.txt", "r");
    if (fd == 0) begin
      failures++;
      $display("could not open the input file");
    end else begin
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        if (n < 2 || line.substr(0, 0) == "#") continue;
        n = $sscanf(line, "%s %h %h %h", cmd, addr, data, id);
        addr = addr & ~32'hf;
        if (cmd == "flush") begin
          flush_i = 1'b1;
          @(posedge clk_i);
          #1;
          flush_i = 1'b0;
          // Dirty lines are dropped, so memory holds the truth again
          model.delete();
          dirty_line.delete();
          have_prev = 1'b0;
        end else begin
          do_request(cmd == "write", addr, {4{data}}, id,
                     cmd == "read" && have_prev && addr == prev_line);
          prev_line = addr;
          have_prev = 1'b1;
        end
      end
      $fclose(fd);
    end
    if (wb_count == 0) begin
      failures++;
      $display("no dirty line was written back to memory");
    end
    $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* l2_cache.f */
hw/l2_pkg.sv
hw/l2_array_if.sv
hw/l2_miss_if.sv
hw/l2_set_ram.sv
hw/l2_store.sv
hw/l2_lookup_stage.sv
hw/l2_miss_stage.sv
hw/l2_cache.sv
verif/l2_cache_properties.sv
verif/tb_l2_cache.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the L2 cache testbench with Verilator, run it and check the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --top-module tb_l2_cache -f l2_cache.f -o sim_l2_cache
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_l2_cache > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "All checks passed" "$LOG"; then
  exit 0
else
  exit 1
fi

/* verif/l2_cache_input.txt */
# Columns: command (read, write, flush), line address (hex), data word (hex), id (hex)
# The data word is repeated four times to form the 128-bit line
read  00000100 00000000 1
read  00000100 00000000 2
read  00000240 00000000 3
write 00000240 deadbeef 4
read  00000240 00000000 5
read  00000240 00000000 6
write 00000580 cafe0001 7
read  00000580 00000000 8
write 00000030 a0000000 9
write 00000230 a0000001 a
write 00000430 a0000002 b
write 00000630 a0000003 c
write 00000830 a0000004 d
write 00000a30 a0000005 e
write 00000c30 a0000006 f
write 00000e30 a0000007 0
write 00001030 a0000008 1
read  00000030 00000000 2
read  00000030 00000000 3
flush 00000000 00000000 0
read  00000580 00000000 4
read  00000240 00000000 5
read  00000030 00000000 6
